/* bench/rv_asm.svh */
`ifndef rv_asm_svh
`define rv_asm_svh

// register-register op, alt selects sub and sra
function automatic word_t op_rr(input logic [2:0] f3, input logic alt,
                                input reg_addr_t rd, input reg_addr_t rs1,
                                input reg_addr_t rs2);
  insn_t w;
  w.r_fmt.funct7 = alt ? funct7_alt : 7'd0;
  w.r_fmt.rs2    = rs2;
  w.r_fmt.rs1    = rs1;
  w.r_fmt.funct3 = f3;
  w.r_fmt.rd     = rd;
  w.r_fmt.opcode = opcode_op;
  return w;
endfunction

function automatic word_t op_ri(input logic [2:0] f3, input reg_addr_t rd,
                                input reg_addr_t rs1, input logic [11:0] imm);
  insn_t w;
  w.i_fmt.imm    = imm;
  w.i_fmt.rs1    = rs1;
  w.i_fmt.funct3 = f3;
  w.i_fmt.rd     = rd;
  w.i_fmt.opcode = opcode_op_imm;
  return w;
endfunction

// slli, srli, srai with the shift amount in the low imm bits
function automatic word_t shift_ri(input logic [2:0] f3, input logic alt,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [4:0] shamt);
  return op_ri(f3, rd, rs1, {alt ? funct7_alt : 7'd0, shamt});
endfunction

function automatic word_t lui_insn(input reg_addr_t rd, input logic [19:0] imm);
  insn_t w;
  w.u_fmt.imm    = imm;
  w.u_fmt.rd     = rd;
  w.u_fmt.opcode = opcode_lui;
  return w;
endfunction

function automatic word_t store_insn(input logic [2:0] f3, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [11:0] imm);
  insn_t w;
  w.s_fmt.imm_hi = imm[11:5];
  w.s_fmt.rs2    = rs2;
  w.s_fmt.rs1    = rs1;
  w.s_fmt.funct3 = f3;
  w.s_fmt.imm_lo = imm[4:0];
  w.s_fmt.opcode = opcode_store;
  return w;
endfunction

// offset in bytes, bit 0 is dropped by the format
function automatic word_t branch_insn(input logic [2:0] f3, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input logic [12:0] off);
  insn_t w;
  w.b_fmt.imm_12   = off[12];
  w.b_fmt.imm_10_5 = off[10:5];
  w.b_fmt.rs2      = rs2;
  w.b_fmt.rs1      = rs1;
  w.b_fmt.funct3   = f3;
  w.b_fmt.imm_4_1  = off[4:1];
  w.b_fmt.imm_11   = off[11];
  w.b_fmt.opcode   = opcode_branch;
  return w;
endfunction

function automatic word_t ecall_insn();
  insn_t w;
  w              = '0;
  w.i_fmt.opcode = opcode_system;
  return w;
endfunction

`endif

/* bench/tb_rv_core.sv */
module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int imem_words    = 256;
  localparam int halt_timeout  = 500;
  localparam int settle_cycles = 8;

  logic     clk;
  logic     rst;
  word_t    imem_addr;
  word_t    imem_rdata;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  byte_en_t dmem_we;
  logic     halt;

  word_t imem [imem_words];
  int    prog_len;
  word_t rng;

  // stores seen on the data port, and the ones the program should make
  word_t    log_addr [$];
  word_t    log_data [$];
  byte_en_t log_we [$];
  word_t    exp_addr [$];
  word_t    exp_data [$];
  byte_en_t exp_we [$];

  `include "rv_asm.svh"

  rv_core_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  always #5 clk = ~clk;

  assign imem_rdata = imem[imem_addr[9:2]];

  // store monitor
  always @(posedge clk) begin
    if (!rst && dmem_we != '0) begin
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
      log_we.push_back(dmem_we);
    end
  end

  function automatic word_t xorshift32(input word_t s);
    word_t x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_we(input string name, input byte_en_t exp, input byte_en_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  // unused words hold opcode 0, a no-op, tagged with their index
  task automatic clear_program();
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = {i[24:0], 7'b0};
    end
    prog_len = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_we.delete();
  endtask

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t hi;
    hi = (value + 32'h800) >> 12;
    emit(lui_insn(rd, hi[19:0]));
    emit(op_ri(f3_add, rd, rd, value[11:0]));
  endtask

  task automatic expect_store(input word_t addr, input word_t data, input byte_en_t we);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_we.push_back(we);
  endtask

  // sw rs, addr(x0) with addr below 0x800
  task automatic store_word(input reg_addr_t rs, input word_t addr, input word_t data);
    emit(store_insn(f3_sw, rs, 5'd0, addr[11:0]));
    expect_store(addr, data, 4'b1111);
  endtask

  task automatic reset_core();
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    log_addr.delete();
    log_data.delete();
    log_we.delete();
  endtask

  task automatic wait_halt(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!halt) begin
      if (n == halt_timeout) begin
        fail_run($sformatf("%s: timeout, halt not raised after %0d cycles", name, n));
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic run_and_check(input string name);
    reset_core();
    wait_halt(name);
    // halt must hold and no late store may show up
    repeat (settle_cycles) begin
      @(negedge clk);
      check_bit("halt", 1'b1, halt);
    end
    if (log_addr.size() != exp_addr.size()) begin
      fail_run($sformatf("%s: expected %0d stores but logged %0d", name,
                         exp_addr.size(), log_addr.size()));
    end else begin
      for (int i = 0; i < exp_addr.size(); i++) begin
        check_word($sformatf("dmem_addr[%0d]", i), exp_addr[i], log_addr[i]);
        check_word($sformatf("dmem_wdata[%0d]", i), exp_data[i], log_data[i]);
        check_we($sformatf("dmem_we[%0d]", i), exp_we[i], log_we[i]);
      end
    end
  endtask

  task automatic imm_ops_test();
    word_t r [1:11];
    clear_program();
    emit(lui_insn(5'd1, 20'h12345));
    emit(op_ri(f3_add, 5'd2, 5'd1, 12'hff0));
    emit(op_ri(f3_add, 5'd3, 5'd0, 12'hffb));
    emit(op_ri(f3_slt, 5'd4, 5'd3, 12'h003));
    emit(op_ri(f3_sltu, 5'd5, 5'd3, 12'h003));
    emit(op_ri(f3_xor, 5'd6, 5'd2, 12'hfff));
    emit(op_ri(f3_or, 5'd7, 5'd2, 12'h70f));
    emit(op_ri(f3_and, 5'd8, 5'd2, 12'h8ff));
    emit(shift_ri(f3_sll, 1'b0, 5'd9, 5'd2, 5'd4));
    emit(shift_ri(f3_sr, 1'b0, 5'd10, 5'd3, 5'd28));
    emit(shift_ri(f3_sr, 1'b1, 5'd11, 5'd3, 5'd1));
    r[1]  = 32'h12345 << 12;
    r[2]  = r[1] - 32'd16;
    r[3]  = 32'hffff_fffb;
    // -5 < 3 signed, but 0xfffffffb is not below 3 unsigned
    r[4]  = 32'd1;
    r[5]  = 32'd0;
    r[6]  = ~r[2];
    r[7]  = r[2] | 32'h0000_070f;
    r[8]  = r[2] & 32'hffff_f8ff;
    r[9]  = r[2] << 4;
    r[10] = r[3] >> 28;
    r[11] = 32'hffff_fffd;
    for (int k = 1; k <= 11; k++) begin
      store_word(reg_addr_t'(k), word_t'(4 * k), r[k]);
    end
    emit(ecall_insn());
    run_and_check("imm ops");
  endtask

  task automatic reg_ops_test();
    logic [2:0] f3s [10];
    logic       alts [10];
    word_t      e [10];
    word_t      a;
    word_t      b;
    f3s  = '{f3_add, f3_add, f3_xor, f3_or, f3_and, f3_sll, f3_sr, f3_sr, f3_slt, f3_sltu};
    alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    for (int round = 0; round < 4; round++) begin
      rng = xorshift32(rng);
      a   = rng;
      rng = xorshift32(rng);
      b   = rng;
      // opposite signs every other round, so slt and sltu disagree
      if (round % 2 == 0) begin
        a[31] = ~b[31];
      end
      e[0] = a + b;
      e[1] = a - b;
      e[2] = a ^ b;
      e[3] = a | b;
      e[4] = a & b;
      e[5] = a << b[4:0];
      e[6] = a >> b[4:0];
      e[7] = word_t'($signed(a) >>> b[4:0]);
      e[8] = {31'b0, $signed(a) < $signed(b)};
      e[9] = {31'b0, a < b};
      clear_program();
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int k = 0; k < 10; k++) begin
        emit(op_rr(f3s[k], alts[k], reg_addr_t'(k + 3), 5'd1, 5'd2));
      end
      for (int k = 0; k < 10; k++) begin
        store_word(reg_addr_t'(k + 3), word_t'(4 * k), e[k]);
      end
      emit(ecall_insn());
      run_and_check($sformatf("reg ops round %0d", round));
    end
  endtask

  task automatic branch_test();
    logic [2:0] f3s [12];
    reg_addr_t  lhs [12];
    reg_addr_t  rhs [12];
    word_t      mark;
    // x1 = 5, x2 = -3, x3 = 5; even entries take the branch
    f3s = '{f3_beq, f3_beq, f3_bne, f3_bne, f3_blt, f3_blt,
            f3_bge, f3_bge, f3_bltu, f3_bltu, f3_bgeu, f3_bgeu};
    lhs = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    rhs = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    clear_program();
    emit(op_ri(f3_add, 5'd1, 5'd0, 12'd5));
    emit(op_ri(f3_add, 5'd2, 5'd0, 12'hffd));
    emit(op_ri(f3_add, 5'd3, 5'd0, 12'd5));
    emit(op_ri(f3_add, 5'd4, 5'd0, 12'h0aa));
    emit(op_ri(f3_add, 5'd5, 5'd0, 12'h055));
    for (int k = 0; k < 12; k++) begin
      mark = word_t'(32'h100 + 8 * k);
      // a taken branch jumps over the marker store
      emit(branch_insn(f3s[k], lhs[k], rhs[k], 13'd8));
      emit(store_insn(f3_sw, 5'd4, 5'd0, mark[11:0]));
      if (k % 2 != 0) begin
        expect_store(mark, 32'h0000_00aa, 4'b1111);
      end
      store_word(5'd5, mark + 32'd4, 32'h0000_0055);
    end
    emit(ecall_insn());
    run_and_check("branches");
  endtask

  task automatic narrow_store_test();
    clear_program();
    emit(op_ri(f3_add, 5'd1, 5'd0, 12'h200));
    load_const(5'd2, 32'ha1b2_c3d4);
    for (int k = 0; k < 4; k++) begin
      emit(store_insn(f3_sb, 5'd2, 5'd1, 12'(k)));
      expect_store(32'h200, 32'hd4d4_d4d4, byte_en_t'(1 << k));
    end
    emit(store_insn(f3_sh, 5'd2, 5'd1, 12'd0));
    expect_store(32'h200, 32'hc3d4_c3d4, 4'b0011);
    emit(store_insn(f3_sh, 5'd2, 5'd1, 12'd2));
    expect_store(32'h200, 32'hc3d4_c3d4, 4'b1100);
    // negative offsets land in the word below the base
    emit(store_insn(f3_sb, 5'd2, 5'd1, 12'hfff));
    expect_store(32'h1fc, 32'hd4d4_d4d4, 4'b1000);
    emit(store_insn(f3_sh, 5'd2, 5'd1, 12'hffe));
    expect_store(32'h1fc, 32'hc3d4_c3d4, 4'b1100);
    emit(ecall_insn());
    run_and_check("narrow stores");
  endtask

  task automatic x0_test();
    clear_program();
    emit(op_ri(f3_add, 5'd1, 5'd0, 12'd7));
    emit(op_ri(f3_add, 5'd0, 5'd0, 12'd123));
    emit(lui_insn(5'd0, 20'hfffff));
    emit(op_rr(f3_add, 1'b0, 5'd0, 5'd1, 5'd1));
    store_word(5'd0, 32'h40, 32'd0);
    emit(op_ri(f3_add, 5'd3, 5'd0, 12'd0));
    store_word(5'd3, 32'h44, 32'd0);
    emit(store_insn(f3_sb, 5'd0, 5'd0, 12'h049));
    expect_store(32'h48, 32'd0, 4'b0010);
    store_word(5'd1, 32'h4c, 32'd7);
    emit(ecall_insn());
    run_and_check("register zero");
  endtask

  task automatic halt_test();
    clear_program();
    emit(op_ri(f3_add, 5'd1, 5'd0, 12'd9));
    store_word(5'd1, 32'h20, 32'd9);
    // ecall sits at byte address 8
    emit(ecall_insn());
    emit(store_insn(f3_sw, 5'd1, 5'd0, 12'h024));
    emit(store_insn(f3_sw, 5'd1, 5'd0, 12'h028));
    run_and_check("halt");
    check_word("imem_addr", 32'd8, imem_addr);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    rng = 32'd27881;
    clear_program();
    imm_ops_test();
    reg_ops_test();
    branch_test();
    narrow_store_test();
    x0_test();
    halt_test();
    $display("Test OK");
    $finish;
  end

endmodule

/* project.f */
+incdir+bench
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_regfile_if.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_pc_unit.sv
src/rv_store_unit.sv
src/rv_core_top.sv
bench/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -j 0 --top-module tb_rv_core -f project.f \
  --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

/* src/rv_alu.sv */
module rv_alu (
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  input  rv_core_pkg::alu_op_t op,
  output rv_isa_pkg::word_t    result
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic       sub_sel;
  word_t      b_eff;
  word_t      sum;
  logic [4:0] shamt;

  // one adder serves add and sub
  assign sub_sel = op == alu_sub;
  assign b_eff   = sub_sel ? ~b : b;
  assign sum     = a + b_eff + {{(xlen-1){1'b0}}, sub_sel};
  assign shamt   = b[4:0];

  always_comb begin
    case (op)
      alu_add,
      alu_sub: result = sum;
      alu_sll: result = a << shamt;
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, a < b};
      end
      alu_xor: result = a ^ b;
      alu_srl: result = a >> shamt;
      // sign fill from bit 31
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_or:  result = a | b;
      alu_and: result = a & b;
      default: result = b;
    endcase
  end

endmodule

/* src/rv_core_pkg.sv */
package rv_core_pkg;

  // data memory byte lanes per word
  localparam int num_lanes = 4;

  typedef logic [num_lanes-1:0] byte_en_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // operand b straight through, for LUI
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } store_size_t;

endpackage

/* src/rv_core_top.sv */
module rv_core_top (
  input  logic                  clk,
  input  logic                  rst,
  output rv_isa_pkg::word_t     imem_addr,
  input  rv_isa_pkg::word_t     imem_rdata,
  output rv_isa_pkg::word_t     dmem_addr,
  output rv_isa_pkg::word_t     dmem_wdata,
  output rv_core_pkg::byte_en_t dmem_we,
  output logic                  halt
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  alu_op_t     alu_op;
  word_t       imm;
  word_t       alu_b;
  word_t       alu_result;
  logic        is_branch;
  logic        is_ecall;
  logic [2:0]  branch_funct;
  logic        store_en;
  store_size_t store_size;

  rv_regfile_if rf_bus ();

  rv_decoder decoder_i (
    .insn         (imem_rdata),
    .halt         (halt),
    .rf           (rf_bus),
    .alu_result   (alu_result),
    .alu_op       (alu_op),
    .imm          (imm),
    .alu_b        (alu_b),
    .is_branch    (is_branch),
    .is_ecall     (is_ecall),
    .branch_funct (branch_funct),
    .store_en     (store_en),
    .store_size   (store_size)
  );

  rv_regfile regfile_i (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus)
  );

  rv_alu alu_i (
    .a      (rf_bus.rs1_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  // pc goes straight out as the fetch address
  rv_pc_unit pc_unit_i (
    .clk          (clk),
    .rst          (rst),
    .rs1_data     (rf_bus.rs1_data),
    .rs2_data     (rf_bus.rs2_data),
    .is_branch    (is_branch),
    .branch_funct (branch_funct),
    .imm          (imm),
    .is_ecall     (is_ecall),
    .pc           (imem_addr),
    .halt         (halt)
  );

  rv_store_unit store_unit_i (
    .base     (rf_bus.rs1_data),
    .offset   (imm),
    .data     (rf_bus.rs2_data),
    .store_en (store_en),
    .size     (store_size),
    .addr     (dmem_addr),
    .wdata    (dmem_wdata),
    .we       (dmem_we)
  );

endmodule

/* src/rv_decoder.sv */
module rv_decoder (
  input  rv_isa_pkg::word_t         insn,
  input  logic                      halt,
  rv_regfile_if.dec                 rf,
  input  rv_isa_pkg::word_t         alu_result,
  output rv_core_pkg::alu_op_t      alu_op,
  output rv_isa_pkg::word_t         imm,
  output rv_isa_pkg::word_t         alu_b,
  output logic                      is_branch,
  output logic                      is_ecall,
  output logic [2:0]                branch_funct,
  output logic                      store_en,
  output rv_core_pkg::store_size_t  store_size
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  insn_t w;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  logic  use_imm;
  logic  wr_req;
  logic  store_req;

  // alt picks sub or arithmetic shift
  function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign w = insn;

  // sign-extended immediates
  assign imm_i = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
  assign imm_s = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
  assign imm_b = {{20{w.b_fmt.imm_12}}, w.b_fmt.imm_11, w.b_fmt.imm_10_5,
                  w.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {w.u_fmt.imm, 12'b0};

  always_comb begin
    alu_op     = alu_add;
    imm        = imm_i;
    use_imm    = 1'b0;
    wr_req     = 1'b0;
    is_branch  = 1'b0;
    is_ecall   = 1'b0;
    store_req  = 1'b0;
    store_size = size_word;
    case (w.r_fmt.opcode)
      opcode_lui: begin
        alu_op  = alu_pass_b;
        imm     = imm_u;
        use_imm = 1'b1;
        wr_req  = 1'b1;
      end
      opcode_op_imm: begin
        // upper imm bits only mean srai on the right-shift variant
        alu_op  = alu_sel(w.i_fmt.funct3,
                          w.i_fmt.funct3 == f3_sr && w.r_fmt.funct7 == funct7_alt);
        use_imm = 1'b1;
        wr_req  = 1'b1;
      end
      opcode_op: begin
        alu_op = alu_sel(w.r_fmt.funct3, w.r_fmt.funct7 == funct7_alt);
        // mul/div encodings fall through as no-ops
        wr_req = w.r_fmt.funct7 == 7'd0 || w.r_fmt.funct7 == funct7_alt;
      end
      opcode_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      opcode_store: begin
        imm       = imm_s;
        store_req = w.s_fmt.funct3 == f3_sb || w.s_fmt.funct3 == f3_sh ||
                    w.s_fmt.funct3 == f3_sw;
        if (w.s_fmt.funct3 == f3_sb) begin
          store_size = size_byte;
        end else if (w.s_fmt.funct3 == f3_sh) begin
          store_size = size_half;
        end
      end
      opcode_system: begin
        // ecall only, every other field zero
        is_ecall = w.i_fmt.imm == 12'd0 && w.i_fmt.rs1 == 5'd0 &&
                   w.i_fmt.funct3 == 3'd0 && w.i_fmt.rd == 5'd0;
      end
      default: begin
      end
    endcase
  end

  assign rf.rs1     = w.r_fmt.rs1;
  assign rf.rs2     = w.r_fmt.rs2;
  assign rf.rd      = w.r_fmt.rd;
  assign rf.wr_data = alu_result;
  // no side effects once halted
  assign rf.wr_en   = wr_req && !halt && w.r_fmt.rd != 5'd0;
  assign store_en   = store_req && !halt;

  assign alu_b        = use_imm ? imm : rf.rs2_data;
  assign branch_funct = w.b_fmt.funct3;

endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    opcode_lui    = 7'b0110111,
    opcode_op_imm = 7'b0010011,
    opcode_op     = 7'b0110011,
    opcode_branch = 7'b1100011,
    opcode_store  = 7'b0100011,
    opcode_system = 7'b1110011
  } opcode_t;

  // alu funct3, shared by OP and OP_IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // store funct3
  localparam logic [2:0] f3_sb = 3'b000;
  localparam logic [2:0] f3_sh = 3'b001;
  localparam logic [2:0] f3_sw = 3'b010;

  // selects SUB, SRA and SRAI
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one fetched word, viewed in each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } insn_t;

endpackage

/* src/rv_pc_unit.sv */
module rv_pc_unit (
  input  logic              clk,
  input  logic              rst,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t rs2_data,
  input  logic              is_branch,
  input  logic [2:0]        branch_funct,
  input  rv_isa_pkg::word_t imm,
  input  logic              is_ecall,
  output rv_isa_pkg::word_t pc,
  output logic              halt
);
  import rv_isa_pkg::*;

  logic  taken;
  word_t next_pc;

  always_comb begin
    case (branch_funct)
      f3_beq:  taken = rs1_data == rs2_data;
      f3_bne:  taken = rs1_data != rs2_data;
      f3_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: taken = rs1_data < rs2_data;
      f3_bgeu: taken = rs1_data >= rs2_data;
      // reserved encodings fall through
      default: taken = 1'b0;
    endcase
  end

  assign next_pc = (is_branch && taken) ? pc + imm : pc + 32'd4;

  // halt is sticky until reset, pc parks on the ecall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ecall) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

/* src/rv_regfile.sv */
module rv_regfile (
  input logic   clk,
  input logic   rst,
  rv_regfile_if.rf rf
);
  import rv_isa_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr_en && rf.rd != 5'd0) begin
      regs[rf.rd] <= rf.wr_data;
    end
  end

  always_comb begin
    rf.rs1_data = '0;
    rf.rs2_data = '0;
    if (rf.rs1 != 5'd0) begin
      rf.rs1_data = regs[rf.rs1];
    end
    if (rf.rs2 != 5'd0) begin
      rf.rs2_data = regs[rf.rs2];
    end
  end

endmodule

/* src/rv_regfile_if.sv */
interface rv_regfile_if;
  import rv_isa_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd;
  word_t     wr_data;
  logic      wr_en;

  // decoder side, picks indices and issues the write
  modport dec (
    output rs1, rs2, rd, wr_data, wr_en,
    input  rs2_data
  );

  modport rf (
    input  rs1, rs2, rd, wr_data, wr_en,
    output rs1_data, rs2_data
  );

endinterface

/* src/rv_store_unit.sv */
module rv_store_unit (
  input  rv_isa_pkg::word_t         base,
  input  rv_isa_pkg::word_t         offset,
  input  rv_isa_pkg::word_t         data,
  input  logic                      store_en,
  input  rv_core_pkg::store_size_t  size,
  output rv_isa_pkg::word_t         addr,
  output rv_isa_pkg::word_t         wdata,
  output rv_core_pkg::byte_en_t     we
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  word_t    ea;
  byte_en_t lanes;

  assign ea   = base + offset;
  // word aligned, lanes pick the bytes
  assign addr = {ea[xlen-1:2], 2'b00};

  always_comb begin
    case (size)
      size_byte: begin
        wdata = {4{data[7:0]}};
        lanes = byte_en_t'(4'b0001 << ea[1:0]);
      end
      size_half: begin
        wdata = {2{data[15:0]}};
        lanes = ea[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = data;
        lanes = 4'b1111;
      end
    endcase
  end

  assign we = store_en ? lanes : '0;

endmodule
